// ==== design/router_defines.svh ====
// router width, depth and mesh size macros
`ifndef ROUTER_DEFINES_SVH
`define ROUTER_DEFINES_SVH

// mesh geometry
`define ROUTER_COORD_W   2   // bits per x or y coordinate
`define ROUTER_MESH_DIM  4   // tiles per row / per column

// transaction payload
`define ROUTER_DATA_W    16

// entries in each virtual output queue
`define ROUTER_VOQ_DEPTH 2

`endif

// ==== design/router_pkg.sv ====
// router types: direction enum, tile id, transaction, ready struct, xy route helpers
`include "router_defines.svh"

package router_pkg;

    // port / arbiter direction, also the index of every per-port array
    typedef enum logic [2:0] {
        DIR_NORTH = 3'd0,
        DIR_EAST  = 3'd1,
        DIR_SOUTH = 3'd2,
        DIR_WEST  = 3'd3,
        DIR_LOCAL = 3'd4
    } t_dir;

    typedef struct packed {
        logic [`ROUTER_COORD_W-1:0] x;
        logic [`ROUTER_COORD_W-1:0] y;  // grows southward
    } t_tile_id;

    typedef struct packed {
        t_tile_id                  dest;
        t_tile_id                  src;
        t_dir                      next_dir;  // lookahead output at the receiver
        logic [`ROUTER_DATA_W-1:0] data;
    } t_tile_trans;

    // one bit per arbiter of the receiving router
    typedef struct packed {
        logic north_arb;
        logic east_arb;
        logic south_arb;
        logic west_arb;
        logic local_arb;
    } t_fab_ready;

    // dimension order: x first, then y
    function automatic t_dir route_xy(t_tile_id cur, t_tile_id dest);
        if (dest.x > cur.x) return DIR_EAST;
        if (dest.x < cur.x) return DIR_WEST;
        if (dest.y > cur.y) return DIR_SOUTH;
        if (dest.y < cur.y) return DIR_NORTH;
        return DIR_LOCAL;
    endfunction

    // pick the ready bit that belongs to one arbiter
    function automatic logic dir_ready(t_fab_ready rdy, t_dir dir);
        case (dir)
            DIR_NORTH: return rdy.north_arb;
            DIR_EAST:  return rdy.east_arb;
            DIR_SOUTH: return rdy.south_arb;
            DIR_WEST:  return rdy.west_arb;
            default:   return rdy.local_arb;
        endcase
    endfunction

endpackage

// ==== design/router_input_port.sv ====
// router input port: four virtual output queues, head offer and room report
`timescale 1ns/1ps
`include "router_defines.svh"

module router_input_port #(
    parameter router_pkg::t_dir PORT_DIR = router_pkg::DIR_NORTH
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          in_valid,
    input  var router_pkg::t_tile_trans   in_trans,
    output router_pkg::t_fab_ready        in_ready_out,  // room per queue
    output logic                    [4:0] head_valid,    // indexed by output dir
    output router_pkg::t_tile_trans [4:0] head_trans,
    input  logic                    [4:0] grant          // pop, same cycle
);
    import router_pkg::*;

    localparam int DEPTH = `ROUTER_VOQ_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [4:0] room;

    for (genvar q = 0; q < 5; q++) begin : g_voq
        if (q == int'(PORT_DIR)) begin : g_uturn
            // no u-turn, queue never exists
            assign head_valid[q] = 1'b0;
            assign head_trans[q] = '0;
            assign room[q]       = 1'b0;
        end else begin : g_fifo
            t_tile_trans      mem [DEPTH];
            logic [PTR_W-1:0] wr_ptr;
            logic [PTR_W-1:0] rd_ptr;
            logic [CNT_W-1:0] count;
            logic             push;
            logic             pop;

            assign push = in_valid && (in_trans.next_dir == t_dir'(q));  // steer by lookahead
            assign pop  = grant[q];

            always_ff @(posedge clk) begin
                if (push) mem[wr_ptr] <= in_trans;
            end

            always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                    wr_ptr <= '0;
                    rd_ptr <= '0;
                    count  <= '0;
                end else begin
                    if (push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                    if (pop)  rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                    case ({push, pop})
                        2'b10:   count <= count + 1'b1;
                        2'b01:   count <= count - 1'b1;
                        default: ;  // both or neither, level unchanged
                    endcase
                end
            end

            assign head_valid[q] = (count != '0);
            assign head_trans[q] = mem[rd_ptr];
            assign room[q]       = (count != CNT_W'(DEPTH));  // drops the cycle after filling
        end
    end

    assign in_ready_out = '{
        north_arb: room[DIR_NORTH],
        east_arb:  room[DIR_EAST],
        south_arb: room[DIR_SOUTH],
        west_arb:  room[DIR_WEST],
        local_arb: room[DIR_LOCAL]
    };

endmodule

// ==== design/router_output_arbiter.sv ====
// round-robin arbiter over the queue heads bound for one output
`timescale 1ns/1ps

module router_output_arbiter (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                    [4:0] req,         // indexed by input dir
    input  var router_pkg::t_tile_trans [4:0] req_trans,
    input  logic                          stage_ready,
    output logic                    [4:0] grant,       // one-hot
    output logic                          win_valid,
    output router_pkg::t_tile_trans       win_trans
);
    import router_pkg::*;

    localparam int N = 5;

    logic [2:0] ptr_q;    // first candidate to look at
    logic [2:0] win_idx;
    logic       found;

    // scan from the pointer, wrap at N
    always_comb begin
        int idx;
        found   = 1'b0;
        win_idx = ptr_q;
        for (int k = 0; k < N; k++) begin
            idx = (int'(ptr_q) + k) % N;
            if (!found && req[idx]) begin
                found   = 1'b1;
                win_idx = 3'(idx);
            end
        end
    end

    assign grant     = (found && stage_ready) ? (5'b00001 << win_idx) : 5'b00000;
    assign win_valid = |grant;
    assign win_trans = req_trans[win_idx];  // don't care when no grant

    // advance past the winner only on a real grant
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ptr_q <= 3'd0;
        end else if (win_valid) begin
            ptr_q <= (win_idx == 3'(N - 1)) ? 3'd0 : win_idx + 3'd1;
        end
    end

endmodule

// ==== design/router_output_stage.sv ====
// output register with back-pressure hold and lookahead route for the next tile
`timescale 1ns/1ps
`include "router_defines.svh"

module router_output_stage #(
    parameter router_pkg::t_dir PORT_DIR = router_pkg::DIR_NORTH
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  var router_pkg::t_tile_id    local_tile_id,
    input  logic                        win_valid,
    input  var router_pkg::t_tile_trans win_trans,
    output logic                        stage_ready,
    output logic                        out_valid,
    output router_pkg::t_tile_trans     out_trans,
    input  var router_pkg::t_fab_ready  in_ready     // neighbor's room
);
    import router_pkg::*;

    localparam int MAX_C = `ROUTER_MESH_DIM - 1;

    t_tile_id    nb_id;       // tile on the far side of this port
    t_tile_trans load_trans;
    logic        drain;

    // neighbor id, clamped at the mesh edge
    always_comb begin
        nb_id = local_tile_id;
        case (PORT_DIR)
            DIR_NORTH: if (nb_id.y != 0)     nb_id.y = nb_id.y - 1'b1;
            DIR_SOUTH: if (nb_id.y != MAX_C) nb_id.y = nb_id.y + 1'b1;
            DIR_EAST:  if (nb_id.x != MAX_C) nb_id.x = nb_id.x + 1'b1;
            DIR_WEST:  if (nb_id.x != 0)     nb_id.x = nb_id.x - 1'b1;
            default:   ;  // local, core sits here
        endcase
    end

    always_comb begin
        load_trans = win_trans;
        if (PORT_DIR == DIR_LOCAL) load_trans.next_dir = DIR_LOCAL;
        else                       load_trans.next_dir = route_xy(nb_id, win_trans.dest);
    end

    assign drain       = out_valid && dir_ready(in_ready, out_trans.next_dir);
    assign stage_ready = !out_valid || drain;  // empty or leaving this edge

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (win_valid) begin
            out_valid <= 1'b1;
        end else if (drain) begin
            out_valid <= 1'b0;
        end
    end

    // held stable until drained
    always_ff @(posedge clk) begin
        if (win_valid) out_trans <= load_trans;
    end

endmodule

// ==== design/router.sv ====
// five-port xy router: input queues, per-output arbiters, output stages
`timescale 1ns/1ps

module router (
    input  logic                        clk,
    input  logic                        arst_n,
    input  var router_pkg::t_tile_id    local_tile_id,
    // north
    input  logic                        in_north_req_valid,
    input  var router_pkg::t_tile_trans in_north_req,
    output router_pkg::t_fab_ready      out_north_ready,
    output logic                        out_north_req_valid,
    output router_pkg::t_tile_trans     out_north_req,
    input  var router_pkg::t_fab_ready  in_north_ready,
    // east
    input  logic                        in_east_req_valid,
    input  var router_pkg::t_tile_trans in_east_req,
    output router_pkg::t_fab_ready      out_east_ready,
    output logic                        out_east_req_valid,
    output router_pkg::t_tile_trans     out_east_req,
    input  var router_pkg::t_fab_ready  in_east_ready,
    // south
    input  logic                        in_south_req_valid,
    input  var router_pkg::t_tile_trans in_south_req,
    output router_pkg::t_fab_ready      out_south_ready,
    output logic                        out_south_req_valid,
    output router_pkg::t_tile_trans     out_south_req,
    input  var router_pkg::t_fab_ready  in_south_ready,
    // west
    input  logic                        in_west_req_valid,
    input  var router_pkg::t_tile_trans in_west_req,
    output router_pkg::t_fab_ready      out_west_ready,
    output logic                        out_west_req_valid,
    output router_pkg::t_tile_trans     out_west_req,
    input  var router_pkg::t_fab_ready  in_west_ready,
    // local, core side
    input  logic                        in_local_req_valid,
    input  var router_pkg::t_tile_trans in_local_req,
    output router_pkg::t_fab_ready      out_local_ready,
    output logic                        out_local_req_valid,
    output router_pkg::t_tile_trans     out_local_req,
    input  var router_pkg::t_fab_ready  in_local_ready
);
    import router_pkg::*;

    // ==================================================
    // boundary ports gathered into t_dir indexed arrays
    // ==================================================
    logic        [4:0] p_in_valid;
    t_tile_trans [4:0] p_in_trans;
    t_fab_ready  [4:0] p_room;       // our ready, toward the senders
    logic        [4:0] p_out_valid;
    t_tile_trans [4:0] p_out_trans;
    t_fab_ready  [4:0] p_nb_ready;   // neighbors' ready
    t_tile_trans       local_routed;

    // core does no lookahead, route it here
    always_comb begin
        local_routed          = in_local_req;
        local_routed.next_dir = route_xy(local_tile_id, in_local_req.dest);
    end

    assign p_in_valid = {in_local_req_valid, in_west_req_valid, in_south_req_valid,
                         in_east_req_valid, in_north_req_valid};
    assign p_in_trans = {local_routed, in_west_req, in_south_req, in_east_req, in_north_req};
    assign p_nb_ready = {in_local_ready, in_west_ready, in_south_ready,
                         in_east_ready, in_north_ready};
    assign {out_local_ready, out_west_ready, out_south_ready,
            out_east_ready, out_north_ready} = p_room;
    assign {out_local_req_valid, out_west_req_valid, out_south_req_valid,
            out_east_req_valid, out_north_req_valid} = p_out_valid;
    assign {out_local_req, out_west_req, out_south_req,
            out_east_req, out_north_req} = p_out_trans;

    // ==================================================
    // crossbar, queue side [in][out] vs arbiter side [out][in]
    // ==================================================
    logic        [4:0] voq_valid [5];
    t_tile_trans [4:0] voq_trans [5];
    logic        [4:0] voq_grant [5];
    logic        [4:0] arb_req   [5];
    t_tile_trans [4:0] arb_trans [5];
    logic        [4:0] arb_grant [5];
    logic        [4:0] win_valid;
    t_tile_trans [4:0] win_trans;
    logic        [4:0] stage_ready;

    for (genvar i = 0; i < 5; i++) begin : g_in
        for (genvar j = 0; j < 5; j++) begin : g_out
            assign arb_req[j][i]   = voq_valid[i][j];
            assign arb_trans[j][i] = voq_trans[i][j];
            assign voq_grant[i][j] = arb_grant[j][i];
        end
    end

    // one slice per direction
    for (genvar d = 0; d < 5; d++) begin : g_port
        router_input_port #(.PORT_DIR(t_dir'(d))) u_in (
            .clk         (clk),
            .arst_n      (arst_n),
            .in_valid    (p_in_valid[d]),
            .in_trans    (p_in_trans[d]),
            .in_ready_out(p_room[d]),
            .head_valid  (voq_valid[d]),
            .head_trans  (voq_trans[d]),
            .grant       (voq_grant[d])
        );

        router_output_arbiter u_arb (
            .clk        (clk),
            .arst_n     (arst_n),
            .req        (arb_req[d]),
            .req_trans  (arb_trans[d]),
            .stage_ready(stage_ready[d]),
            .grant      (arb_grant[d]),
            .win_valid  (win_valid[d]),
            .win_trans  (win_trans[d])
        );

        router_output_stage #(.PORT_DIR(t_dir'(d))) u_out (
            .clk          (clk),
            .arst_n       (arst_n),
            .local_tile_id(local_tile_id),
            .win_valid    (win_valid[d]),
            .win_trans    (win_trans[d]),
            .stage_ready  (stage_ready[d]),
            .out_valid    (p_out_valid[d]),
            .out_trans    (p_out_trans[d]),
            .in_ready     (p_nb_ready[d])
        );
    end

endmodule

// ==== design/mini_core_tile.sv ====
// mesh tile top: router with all five ports at the tile boundary
`timescale 1ns/1ps

module mini_core_tile (
    input  logic                        clk,
    input  logic                        arst_n,
    input  var router_pkg::t_tile_id    local_tile_id,
    // north fabric
    input  logic                        in_north_req_valid,
    input  var router_pkg::t_tile_trans in_north_req,
    output router_pkg::t_fab_ready      out_north_ready,
    output logic                        out_north_req_valid,
    output router_pkg::t_tile_trans     out_north_req,
    input  var router_pkg::t_fab_ready  in_north_ready,
    // east fabric
    input  logic                        in_east_req_valid,
    input  var router_pkg::t_tile_trans in_east_req,
    output router_pkg::t_fab_ready      out_east_ready,
    output logic                        out_east_req_valid,
    output router_pkg::t_tile_trans     out_east_req,
    input  var router_pkg::t_fab_ready  in_east_ready,
    // south fabric
    input  logic                        in_south_req_valid,
    input  var router_pkg::t_tile_trans in_south_req,
    output router_pkg::t_fab_ready      out_south_ready,
    output logic                        out_south_req_valid,
    output router_pkg::t_tile_trans     out_south_req,
    input  var router_pkg::t_fab_ready  in_south_ready,
    // west fabric
    input  logic                        in_west_req_valid,
    input  var router_pkg::t_tile_trans in_west_req,
    output router_pkg::t_fab_ready      out_west_ready,
    output logic                        out_west_req_valid,
    output router_pkg::t_tile_trans     out_west_req,
    input  var router_pkg::t_fab_ready  in_west_ready,
    // local, core stand-in drives these
    input  logic                        in_local_req_valid,
    input  var router_pkg::t_tile_trans in_local_req,
    output router_pkg::t_fab_ready      out_local_ready,
    output logic                        out_local_req_valid,
    output router_pkg::t_tile_trans     out_local_req,
    input  var router_pkg::t_fab_ready  in_local_ready
);

    // port names match one to one
    router u_router (.*);

endmodule

// ==== tb/tile_tb.sv ====
// clock, reset, fabric and core drivers, receivers, checker and timeout of the tile testbench
`timescale 1ns/1ps
`include "router_defines.svh"

module tile_tb;
    import router_pkg::*;

    localparam int NUM_LINES = 32;
    localparam int LIMIT     = 50 * NUM_LINES + 200;  // cycles
    localparam int DEPTH     = `ROUTER_VOQ_DEPTH;

    logic              clk;
    logic              arst_n;
    t_tile_id          tile_id;
    logic        [4:0] drv_valid;   // all arrays indexed by t_dir value
    t_tile_trans [4:0] drv_trans;
    t_fab_ready  [4:0] drv_ready;   // downstream room per output
    t_fab_ready  [4:0] room;
    logic        [4:0] ovalid;
    t_tile_trans [4:0] otrans;

    logic [15:0] stim [NUM_LINES*6];
    int          pend [5][$];          // lines not yet sent per input
    logic [30:0] flow_q [5][5][$];     // {lat, stall, next_dir, dest, data}
    int          flow_cyc [5][5][$];   // cycle the request was presented
    int          flow_acc [5][5];      // inside the router
    int          pend_acc [5][5];      // sent this cycle and counted in the next
    logic [4:0]  owed [5][5];          // [out][in] inputs due before in again
    logic [4:0]  seen;
    int          stall_left [5];
    t_tile_trans held [5];
    logic [31:0] lfsr;
    int          cyc;
    int          live;
    int          line;

    mini_core_tile u_dut (
        .clk                (clk),
        .arst_n             (arst_n),
        .local_tile_id      (tile_id),
        .in_north_req_valid (drv_valid[0]),
        .in_north_req       (drv_trans[0]),
        .out_north_ready    (room[0]),
        .out_north_req_valid(ovalid[0]),
        .out_north_req      (otrans[0]),
        .in_north_ready     (drv_ready[0]),
        .in_east_req_valid  (drv_valid[1]),
        .in_east_req        (drv_trans[1]),
        .out_east_ready     (room[1]),
        .out_east_req_valid (ovalid[1]),
        .out_east_req       (otrans[1]),
        .in_east_ready      (drv_ready[1]),
        .in_south_req_valid (drv_valid[2]),
        .in_south_req       (drv_trans[2]),
        .out_south_ready    (room[2]),
        .out_south_req_valid(ovalid[2]),
        .out_south_req      (otrans[2]),
        .in_south_ready     (drv_ready[2]),
        .in_west_req_valid  (drv_valid[3]),
        .in_west_req        (drv_trans[3]),
        .out_west_ready     (room[3]),
        .out_west_req_valid (ovalid[3]),
        .out_west_req       (otrans[3]),
        .in_west_ready      (drv_ready[3]),
        .in_local_req_valid (drv_valid[4]),
        .in_local_req       (drv_trans[4]),
        .out_local_ready    (room[4]),
        .out_local_req_valid(ovalid[4]),
        .out_local_req      (otrans[4]),
        .in_local_ready     (drv_ready[4])
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ==================================================
    // helpers
    // ==================================================
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
    endfunction

    // tile id of whoever drives input d
    function automatic logic [3:0] src_of(int d);
        case (d)
            0:       return 4'h4;   // (1,0)
            1:       return 4'h9;   // (2,1)
            2:       return 4'h6;   // (1,2)
            3:       return 4'h1;   // (0,1)
            default: return 4'h5;   // core at (1,1)
        endcase
    endfunction

    function automatic int in_of(logic [3:0] s);
        for (int d = 0; d < 5; d++) begin
            if (src_of(d) == s) return d;
        end
        return -1;
    endfunction

    function automatic logic ready_bit(logic [4:0] r, int d);
        return r[4-d];  // north_arb is the msb
    endfunction

    task automatic check(input logic [31:0] act, input logic [31:0] exp, input string msg);
        if (act !== exp) begin
            $display("mismatch at %0t ns: %s, got %0h expected %0h", $time, msg, act, exp);
            $display("RESULT: FAIL");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic abort_run(input string msg);
        $display("%s at %0t ns", msg, $time);
        $display("RESULT: FAIL");
        $fatal(1, "stopped on error");
    endtask

    // outputs quiet and every real queue has room
    task automatic check_idle(input string when);
        for (int d = 0; d < 5; d++) begin
            check(ovalid[d], 0, $sformatf("out valid %0d %s", d, when));
            check(room[d], 5'b11111 & ~(5'b10000 >> d), $sformatf("ready %0d %s", d, when));
        end
    endtask

    function automatic logic all_sent();
        for (int i = 0; i < 5; i++) begin
            if (pend[i].size() != 0) return 1'b0;
        end
        return 1'b1;
    endfunction

    // first cycle an output shows a transaction
    task automatic new_out(input int o);
        int          i;
        logic [30:0] ent;
        i = in_of(otrans[o].src);
        if (i < 0 || flow_q[i][o].size() == 0) begin
            abort_run($sformatf("unexpected transaction on output %0d", o));
        end
        ent           = flow_q[i][o][0];
        seen[o]       = 1'b1;
        held[o]       = otrans[o];
        stall_left[o] = int'(ent[29:23]);
        if (ent[30]) check(cyc - flow_cyc[i][o][0], 2, "uncongested latency");
    endtask

    // ==================================================
    // drive point 2 ns after the rising edge
    // ==================================================
    task automatic drive_phase();
        int          n_inj;
        int          fi;
        int          fo;
        int          ln;
        int          o;
        logic [30:0] ent;
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                flow_acc[i][j] += pend_acc[i][j];  // written into the queue last edge
                pend_acc[i][j] = 0;
            end
        end
        // a barrier line holds the next wave until the router is empty
        if (all_sent() && line < NUM_LINES && (!stim[line*6+5][7] || live == 0)) begin
            do begin
                pend[int'(stim[line*6][2:0])].push_back(line);
                line++;
            end while (line < NUM_LINES && !stim[line*6+5][7]);
        end
        n_inj     = 0;
        fi        = 0;
        fo        = 0;
        drv_valid = '0;
        for (int i = 0; i < 5; i++) begin
            if (pend[i].size() != 0) begin
                ln = pend[i][0];
                o  = int'(stim[ln*6+3][2:0]);
                if (ready_bit(room[i], o)) begin  // only send into room
                    void'(pend[i].pop_front());
                    drv_valid[i]          = 1'b1;
                    drv_trans[i].dest     = t_tile_id'(stim[ln*6+1][3:0]);
                    drv_trans[i].src      = t_tile_id'(src_of(i));
                    drv_trans[i].next_dir = (i == 4) ? DIR_NORTH : t_dir'(o);  // core sends junk
                    drv_trans[i].data     = stim[ln*6+2];
                    ent = {1'b0, stim[ln*6+5][6:0], stim[ln*6+4][2:0],
                           stim[ln*6+1][3:0], stim[ln*6+2]};
                    flow_q[i][o].push_back(ent);
                    flow_cyc[i][o].push_back(cyc);
                    pend_acc[i][o]++;
                    if (n_inj == 0) begin
                        fi = i;
                        fo = o;
                    end
                    n_inj++;
                end
            end
        end
        // lone request into an empty router
        if (n_inj == 1 && live == 0) begin
            ent     = flow_q[fi][fo].pop_back();
            ent[30] = 1'b1;
            flow_q[fi][fo].push_back(ent);
        end
        live += n_inj;
        // receivers stretch each stall at random
        for (int k = 0; k < 5; k++) begin
            if (ovalid[k] && !seen[k]) new_out(k);
            if (seen[k] && stall_left[k] > 0) begin
                drv_ready[k] = '0;
                lfsr = lfsr_step(lfsr);
                if (lfsr[0]) stall_left[k]--;
            end else begin
                drv_ready[k] = '1;
            end
        end
    endtask

    // ==================================================
    // sample point on the falling edge
    // ==================================================
    task automatic sample_phase();
        int          i;
        logic [30:0] ent;
        // full queue behind a held output must refuse more
        for (int a = 0; a < 5; a++) begin
            for (int b = 0; b < 5; b++) begin
                if (flow_acc[a][b] == DEPTH + 1) begin
                    check(ready_bit(room[a], b), 0, $sformatf("ready %0d->%0d when full", a, b));
                end
            end
        end
        for (int o = 0; o < 5; o++) begin
            if (seen[o]) begin
                check(ovalid[o], 1, "valid dropped while held");
                check(otrans[o], held[o], "held transaction changed");
                if (ready_bit(drv_ready[o], int'(otrans[o].next_dir))) begin  // leaves next edge
                    i   = in_of(otrans[o].src);
                    ent = flow_q[i][o].pop_front();
                    void'(flow_cyc[i][o].pop_front());
                    check(otrans[o].data, ent[15:0], "payload");
                    check(otrans[o].dest, ent[19:16], "dest");
                    check(otrans[o].next_dir, ent[22:20], "lookahead next_dir");
                    check(owed[o][i], 0, $sformatf("round robin at output %0d", o));
                    flow_acc[i][o]--;
                    owed[o][i] = '0;
                    for (int j = 0; j < 5; j++) begin
                        if (j != i) begin
                            owed[o][i][j] = (flow_acc[j][o] > 0);  // all served before i again
                            owed[o][j][i] = 1'b0;
                        end
                    end
                    live--;
                    seen[o] = 1'b0;
                end
            end
        end
    endtask

    initial begin
        tile_id   = 4'h5;  // (1,1)
        arst_n    = 1'b0;
        drv_valid = '0;
        drv_trans = '0;
        drv_ready = '1;
        lfsr      = 32'he142ab6d;
        cyc       = 0;
        live      = 0;
        line      = 0;
        seen      = '0;
        for (int i = 0; i < 5; i++) begin
            stall_left[i] = 0;
            for (int j = 0; j < 5; j++) begin
                flow_acc[i][j] = 0;
                pend_acc[i][j] = 0;
                owed[i][j]     = '0;
            end
        end
        $readmemh("tb/tile_stimulus.txt", stim);
        repeat (4) begin
            @(negedge clk);
            check_idle("in reset");
        end
        @(posedge clk);
        #2 arst_n = 1'b1;
        @(negedge clk);
        check_idle("after reset");
        while (!(line == NUM_LINES && all_sent() && live == 0)) begin
            @(posedge clk);
            cyc++;
            if (cyc > LIMIT) abort_run("timeout with transactions still in flight");
            #2;
            drive_phase();
            @(negedge clk);
            sample_phase();
        end
        repeat (2) @(negedge clk);
        check_idle("after last transaction");
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+design
design/router_pkg.sv
design/router_input_port.sv
design/router_output_arbiter.sv
design/router_output_stage.sv
design/router.sv
design/mini_core_tile.sv
tb/tile_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the tile testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tile_tb -f project.f

./obj_dir/Vtile_tb | tee sim.log

if grep -q "RESULT: PASS" sim.log; then
    exit 0
fi
exit 1

// ==== tb/tile_stimulus.txt ====
// in dest data out next_dir stall, all hex; dirs n=0 e=1 s=2 w=3 local=4
// dest is {x,y}; stall bit 7 waits until the router is empty first
3 d 1001 1 1 80
1 2 1002 3 2 80
0 7 1003 2 2 80
2 4 1004 0 4 80
4 8 1005 1 0 80
3 5 1006 4 4 80
4 0 1007 3 0 80
4 7 1008 2 2 80
4 4 1009 0 4 80
3 c a001 1 1 86
3 d a002 1 1 00
3 c a003 1 1 00
3 e a004 1 1 03
3 d a005 1 1 00
0 6 b001 2 4 04
0 7 b002 2 2 00
0 6 b003 2 4 02
0 5 c001 4 4 85
1 5 c101 4 4 00
2 5 c201 4 4 00
3 5 c301 4 4 00
0 5 c002 4 4 00
1 5 c102 4 4 00
2 5 c202 4 4 02
3 5 c302 4 4 00
0 5 c003 4 4 00
1 5 c103 4 4 00
2 5 c203 4 4 00
3 5 c303 4 4 00
4 f d001 1 1 00
4 f d002 1 1 04
1 1 e001 3 4 00
